/* hw/procPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the 16-bit five-stage core
// opcode sits in instr[15:11]; all addresses are word addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package procPkg;

  typedef logic [15:0] wordT;   // data word, address or instruction
  typedef logic [2:0]  regIdxT;

  typedef enum logic [4:0] {
    opHalt = 5'b00000,
    opNop  = 5'b00001,
    opJ    = 5'b00100,
    opAddi = 5'b01000,
    opBeqz = 5'b01100,
    opSt   = 5'b10000,
    opLd   = 5'b10001,
    opLbi  = 5'b11000,
    opAdd  = 5'b11010,
    opSub  = 5'b11011,
    opAnd  = 5'b11100,
    opXor  = 5'b11101
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluXor,
    aluPassB   // lbi
  } aluOpT;

  typedef struct packed {
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   memToReg;
    logic   isBranch;
    logic   isJump;
    logic   isHalt;   // also set for an illegal opcode
    aluOpT  aluOp;
    logic   useImm;
    regIdxT dest;
    logic   readsRs;
    logic   readsRt;
  } ctrlT;

  typedef struct packed {
    logic valid;
    ctrlT ctrl;
    wordT pcPlus1;
    wordT opA;
    wordT opB;
    wordT imm;   // already sign extended
  } idExT;

  typedef struct packed {
    logic valid;
    ctrlT ctrl;
    wordT aluResult;
    wordT storeData;
  } exMemT;

  typedef struct packed {
    logic   valid;
    logic   regWrite;
    logic   memToReg;
    logic   isHalt;
    regIdxT dest;
    wordT   aluResult;
    wordT   loadData;
  } memWbT;

  // master side of the data bus, ack and datR come back as plain ports
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    wordT adr;
    wordT datW;
  } wbReqT;

endpackage

/* hw/regFile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8 x 16 register file, 2 read ports, 1 write port
// a read of the register being written returns the new value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module regFile (
  input  logic            clk,
  input  logic            rstN,
  input  procPkg::regIdxT rdAddrA,
  input  procPkg::regIdxT rdAddrB,
  output procPkg::wordT   rdDataA,
  output procPkg::wordT   rdDataB,
  input  logic            wrEn,
  input  procPkg::regIdxT wrAddr,
  input  procPkg::wordT   wrData
);

  procPkg::wordT regs [8];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // write-through so writeback and decode can share a cycle
  assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
  assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

/* hw/decodeUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage: control, immediates, register reads
// unknown opcodes decode as a halt and raise illegal
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module decodeUnit (
  input  logic            clk,
  input  logic            rstN,
  input  procPkg::wordT   instr,
  input  logic            instrValid,
  input  logic            wbEn,
  input  procPkg::regIdxT wbAddr,
  input  procPkg::wordT   wbData,
  output procPkg::ctrlT   ctrl,
  output procPkg::wordT   opA,
  output procPkg::wordT   opB,
  output procPkg::wordT   imm,
  output logic            illegal
);

  procPkg::opcodeT opcode;
  procPkg::regIdxT rs, rt, rd;
  procPkg::wordT   imm5, imm8, imm11;
  logic            unknownOp;

  assign opcode = procPkg::opcodeT'(instr[15:11]);
  assign rs     = instr[10:8];
  assign rt     = instr[7:5];
  assign rd     = instr[4:2];

  assign imm5  = {{11{instr[4]}}, instr[4:0]};
  assign imm8  = {{8{instr[7]}}, instr[7:0]};
  assign imm11 = {{5{instr[10]}}, instr[10:0]};

  regFile regs_i (
    .clk    (clk),
    .rstN   (rstN),
    .rdAddrA(rs),
    .rdAddrB(rt),
    .rdDataA(opA),
    .rdDataB(opB),
    .wrEn   (wbEn),
    .wrAddr (wbAddr),
    .wrData (wbData)
  );

  always_comb begin
    ctrl      = '0;
    imm       = imm5;
    unknownOp = 1'b0;
    case (opcode)
      procPkg::opNop: ;
      procPkg::opHalt: ctrl.isHalt = 1'b1;
      procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor: begin
        ctrl.regWrite = 1'b1;
        ctrl.dest     = rd;
        ctrl.readsRs  = 1'b1;
        ctrl.readsRt  = 1'b1;
        ctrl.aluOp    = (opcode == procPkg::opAdd) ? procPkg::aluAdd :
                        (opcode == procPkg::opSub) ? procPkg::aluSub :
                        (opcode == procPkg::opAnd) ? procPkg::aluAnd : procPkg::aluXor;
      end
      procPkg::opAddi, procPkg::opLd: begin
        ctrl.regWrite = 1'b1;
        ctrl.useImm   = 1'b1;
        ctrl.dest     = rt;
        ctrl.readsRs  = 1'b1;
        ctrl.memRead  = (opcode == procPkg::opLd);
        ctrl.memToReg = (opcode == procPkg::opLd);
      end
      procPkg::opLbi: begin
        ctrl.regWrite = 1'b1;
        ctrl.useImm   = 1'b1;
        ctrl.aluOp    = procPkg::aluPassB;
        ctrl.dest     = rs;   // lbi writes the rs field
        imm           = imm8;
      end
      procPkg::opSt: begin
        ctrl.memWrite = 1'b1;
        ctrl.useImm   = 1'b1;   // address = rs + imm5
        ctrl.readsRs  = 1'b1;
        ctrl.readsRt  = 1'b1;
      end
      procPkg::opBeqz: begin
        ctrl.isBranch = 1'b1;
        ctrl.readsRs  = 1'b1;
        imm           = imm8;
      end
      procPkg::opJ: begin
        ctrl.isJump = 1'b1;
        imm         = imm11;
      end
      default: begin
        ctrl.isHalt = 1'b1;   // stop the core behind the bad word
        unknownOp   = 1'b1;
      end
    endcase
  end

  assign illegal = instrValid & unknownOp;

endmodule

/* hw/hazardDetector.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read-after-write check for decode, no forwarding
// writeback is covered by the register file bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module hazardDetector (
  input  procPkg::ctrlT   decCtrl,
  input  logic            decValid,
  input  procPkg::regIdxT rsIdx,
  input  procPkg::regIdxT rtIdx,
  input  procPkg::ctrlT   exCtrl,
  input  logic            exValid,
  input  procPkg::ctrlT   memCtrl,
  input  logic            memValid,
  output logic            stall
);

  logic exHit, memHit;

  assign exHit  = exValid & exCtrl.regWrite &
                  ((decCtrl.readsRs & (exCtrl.dest == rsIdx)) |
                   (decCtrl.readsRt & (exCtrl.dest == rtIdx)));
  assign memHit = memValid & memCtrl.regWrite &
                  ((decCtrl.readsRs & (memCtrl.dest == rsIdx)) |
                   (decCtrl.readsRt & (memCtrl.dest == rtIdx)));

  assign stall = decValid & (exHit | memHit);

endmodule

/* hw/executeUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage: alu, branch test and target
// taken only for a valid beqz with rs == 0, or a valid j
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module executeUnit (
  input  procPkg::idExT idEx,
  output procPkg::wordT result,
  output procPkg::wordT storeData,
  output logic          branchTaken,
  output procPkg::wordT branchTarget
);

  procPkg::wordT aluB;

  assign aluB = idEx.ctrl.useImm ? idEx.imm : idEx.opB;

  always_comb begin
    case (idEx.ctrl.aluOp)
      procPkg::aluAdd:   result = idEx.opA + aluB;
      procPkg::aluSub:   result = idEx.opA - aluB;   // rs - rt
      procPkg::aluAnd:   result = idEx.opA & aluB;
      procPkg::aluXor:   result = idEx.opA ^ aluB;
      procPkg::aluPassB: result = aluB;
      default:           result = '0;
    endcase
  end

  assign storeData = idEx.opB;   // rt of a store

  assign branchTaken = idEx.valid &
                       (idEx.ctrl.isJump | (idEx.ctrl.isBranch & (idEx.opA == '0)));

  // relative to the instruction after the branch
  assign branchTarget = idEx.pcPlus1 + idEx.imm;

endmodule

/* hw/memoryAccess.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic master for ld/st, one word per transfer
// request is combinational from EX/MEM, which holds until ack
// a following ld/st may start right after an ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module memoryAccess (
  input  logic           clk,
  input  logic           rstN,
  input  procPkg::exMemT exMem,
  output procPkg::wbReqT wbReq,
  input  logic           wbAck,
  input  procPkg::wordT  wbDatR,
  output procPkg::wordT  loadData,
  output logic           memBusy
);

  typedef enum logic {
    idle,
    waitAck
  } memStateT;

  memStateT state, stateNext;
  logic     memOp;
  logic     active;

  assign memOp  = exMem.valid & (exMem.ctrl.memRead | exMem.ctrl.memWrite);
  assign active = (state == waitAck) | memOp;

  always_comb begin
    stateNext = state;
    case (state)
      idle:    if (memOp && !wbAck) stateNext = waitAck;
      waitAck: if (wbAck) stateNext = idle;
      default: stateNext = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      state <= stateNext;
    end
  end

  assign wbReq.cyc  = active;
  assign wbReq.stb  = active;
  assign wbReq.we   = exMem.ctrl.memWrite;
  assign wbReq.adr  = exMem.aluResult;
  assign wbReq.datW = exMem.storeData;

  // sampled into MEM/WB on the ack edge
  assign loadData = wbDatR;
  assign memBusy  = active & ~wbAck;

endmodule

/* hw/pipeProc.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// five-stage core, instruction memory answers same cycle
// whole pipe holds while a data transfer waits for ack
// after halt or err nothing moves until reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module pipeProc (
  input  logic           clk,
  input  logic           rstN,
  output procPkg::wordT  imemAddr,
  input  procPkg::wordT  imemData,
  output procPkg::wbReqT wbReq,
  input  logic           wbAck,
  input  procPkg::wordT  wbDatR,
  output logic           halted,
  output logic           err
);

  procPkg::wordT   pc, pcPlus1;
  logic            ifIdValid;
  procPkg::wordT   ifIdInstr, ifIdPcPlus1;
  procPkg::idExT   idEx;
  procPkg::exMemT  exMem;
  procPkg::memWbT  memWb;

  procPkg::ctrlT   decCtrl;
  procPkg::wordT   decOpA, decOpB, decImm;
  logic            decIllegal, decValid;
  logic            stall, hold;
  procPkg::wordT   exResult, exStoreData, branchTarget;
  logic            branchTaken;
  procPkg::wordT   loadData;
  logic            memBusy;
  logic            wbEn;
  procPkg::wordT   wbData;
  logic            draining;     // a halt is in flight, fetch stopped
  logic            illegalSeen;  // that halt came from a bad opcode

  assign pcPlus1  = pc + 16'd1;
  assign imemAddr = pc;
  assign hold     = memBusy | halted;
  assign decValid = ifIdValid & ~draining;

  decodeUnit decode_i (
    .clk       (clk),
    .rstN      (rstN),
    .instr     (ifIdInstr),
    .instrValid(decValid),
    .wbEn      (wbEn),
    .wbAddr    (memWb.dest),
    .wbData    (wbData),
    .ctrl      (decCtrl),
    .opA       (decOpA),
    .opB       (decOpB),
    .imm       (decImm),
    .illegal   (decIllegal)
  );

  hazardDetector hazard_i (
    .decCtrl (decCtrl),
    .decValid(decValid),
    .rsIdx   (ifIdInstr[10:8]),
    .rtIdx   (ifIdInstr[7:5]),
    .exCtrl  (idEx.ctrl),
    .exValid (idEx.valid),
    .memCtrl (exMem.ctrl),
    .memValid(exMem.valid),
    .stall   (stall)
  );

  executeUnit execute_i (
    .idEx        (idEx),
    .result      (exResult),
    .storeData   (exStoreData),
    .branchTaken (branchTaken),
    .branchTarget(branchTarget)
  );

  memoryAccess memory_i (
    .clk     (clk),
    .rstN    (rstN),
    .exMem   (exMem),
    .wbReq   (wbReq),
    .wbAck   (wbAck),
    .wbDatR  (wbDatR),
    .loadData(loadData),
    .memBusy (memBusy)
  );

  // fetch: branch target wins over a stall
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc        <= '0;
      ifIdValid <= 1'b0;
    end else if (!hold) begin
      if (branchTaken) begin
        pc        <= branchTarget;
        ifIdValid <= 1'b0;   // squash the younger fetch
      end else if (!stall && !draining) begin
        pc          <= pcPlus1;
        ifIdValid   <= 1'b1;
        ifIdInstr   <= imemData;
        ifIdPcPlus1 <= pcPlus1;
      end
    end
  end

  // ID/EX gets a bubble on stall, squash or drain
  always_ff @(posedge clk) begin
    if (!rstN) begin
      idEx.valid  <= 1'b0;
      draining    <= 1'b0;
      illegalSeen <= 1'b0;
    end else if (!hold) begin
      idEx.valid   <= decValid & ~stall & ~branchTaken;
      idEx.ctrl    <= decCtrl;
      idEx.pcPlus1 <= ifIdPcPlus1;
      idEx.opA     <= decOpA;
      idEx.opB     <= decOpB;
      idEx.imm     <= decImm;
      if (decValid && decCtrl.isHalt && !stall && !branchTaken) begin
        draining    <= 1'b1;
        illegalSeen <= decIllegal;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMem.valid <= 1'b0;
    end else if (!hold) begin
      exMem.valid     <= idEx.valid;
      exMem.ctrl      <= idEx.ctrl;
      exMem.aluResult <= exResult;
      exMem.storeData <= exStoreData;
    end
  end

  // bubble into writeback while the bus transfer waits
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWb.valid <= 1'b0;
    end else if (!halted) begin
      memWb.valid     <= exMem.valid & ~memBusy;
      memWb.regWrite  <= exMem.ctrl.regWrite;
      memWb.memToReg  <= exMem.ctrl.memToReg;
      memWb.isHalt    <= exMem.ctrl.isHalt;
      memWb.dest      <= exMem.ctrl.dest;
      memWb.aluResult <= exMem.aluResult;
      memWb.loadData  <= loadData;
    end
  end

  assign wbEn   = memWb.valid & memWb.regWrite;
  assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      halted <= 1'b0;
      err    <= 1'b0;
    end else if (memWb.valid && memWb.isHalt) begin
      halted <= 1'b1;
      err    <= illegalSeen;   // older stores have drained by now
    end
  end

endmodule

/* testbench/procTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests for the five-stage core
// data slave acks after 0 to 3 cycles, xorshift driven
// both memories decode only address bits 7..0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module procTb;

  logic           clk;
  logic           rstN;
  procPkg::wordT  imemAddr;
  procPkg::wordT  imemData;
  procPkg::wbReqT wbReq;
  logic           wbAck;
  procPkg::wordT  wbDatR;
  logic           halted;
  logic           err;

  procPkg::wordT imem [256];
  procPkg::wordT dmem [256];
  procPkg::wordT logAdr [$];
  procPkg::wordT logDat [$];
  procPkg::wordT expAdr [$];
  procPkg::wordT expDat [$];
  int            progLen;
  int            padCount;      // nops after every emitted word
  logic [31:0]   rngState;
  logic          pending;
  logic [1:0]    waitLeft;
  logic          busAfterHalt;

  pipeProc dut_i (
    .clk     (clk),
    .rstN    (rstN),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .wbReq   (wbReq),
    .wbAck   (wbAck),
    .wbDatR  (wbDatR),
    .halted  (halted),
    .err     (err)
  );

  assign imemData = imem[imemAddr[7:0]];   // same-cycle fetch

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic procPkg::wordT fillWord(input logic [7:0] a);
    return {a ^ 8'h5a, ~a};
  endfunction

  function automatic procPkg::wordT rType(input procPkg::opcodeT op,
                                          input logic [2:0] rs, rt, rd);
    return {op, rs, rt, rd, 2'b00};
  endfunction

  function automatic procPkg::wordT iType(input procPkg::opcodeT op,
                                          input logic [2:0] rs, rt, input logic [4:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic procPkg::wordT loadImm(input logic [2:0] rs, input logic [7:0] imm);
    return {procPkg::opLbi, rs, imm};
  endfunction

  function automatic procPkg::wordT branchZero(input logic [2:0] rs, input logic [7:0] off);
    return {procPkg::opBeqz, rs, off};
  endfunction

  function automatic procPkg::wordT jumpRel(input logic [10:0] off);
    return {procPkg::opJ, off};
  endfunction

  function automatic procPkg::wordT haltWord();
    return {procPkg::opHalt, 11'd0};
  endfunction

  // wishbone slave, one transfer per ack
  always @(posedge clk) begin
    #1;
    if (!rstN) begin
      wbAck   = 1'b0;
      pending = 1'b0;
    end else begin
      if (wbAck) begin
        wbAck   = 1'b0;   // master took it on this edge
        pending = 1'b0;
      end
      if (halted && wbReq.cyc) busAfterHalt = 1'b1;
      if (wbReq.cyc && wbReq.stb) begin
        if (!pending) begin
          pending  = 1'b1;
          rngState = xorshift(rngState);
          waitLeft = rngState[1:0];
        end
        if (waitLeft == 2'd0) begin
          wbAck = 1'b1;
          if (wbReq.we) begin
            dmem[wbReq.adr[7:0]] = wbReq.datW;
            logAdr.push_back(wbReq.adr);
            logDat.push_back(wbReq.datW);
          end else begin
            wbDatR = dmem[wbReq.adr[7:0]];
          end
        end else begin
          waitLeft = waitLeft - 2'd1;
        end
      end
    end
  end

  task automatic checkEq(input string name, input logic [31:0] expected, actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic newProgram();
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = {procPkg::opNop, 11'd0};
    end
    progLen = 0;
    expAdr.delete();
    expDat.delete();
  endtask

  task automatic emit(input procPkg::wordT w);
    imem[progLen[7:0]] = w;
    progLen++;
    repeat (padCount) begin
      imem[progLen[7:0]] = {procPkg::opNop, 11'd0};
      progLen++;
    end
  endtask

  task automatic expectStore(input procPkg::wordT adr, input procPkg::wordT dat);
    expAdr.push_back(adr);
    expDat.push_back(dat);
  endtask

  task automatic applyReset();
    @(posedge clk);
    #1;
    rstN = 1'b0;
    for (int i = 0; i < 256; i++) begin
      dmem[i[7:0]] = fillWord(i[7:0]);
    end
    repeat (5) @(posedge clk);
    logAdr.delete();
    logDat.delete();
    busAfterHalt = 1'b0;
    #1;
    rstN = 1'b1;
  endtask

  task automatic waitForHalt(input string name);
    int cycles;
    cycles = 0;
    while (halted !== 1'b1) begin
      if (cycles >= 1000) begin
        $display("%s: the core never halted within 1000 cycles", name);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic checkStores(input string name);
    checkEq({name, " store count"}, 32'(expAdr.size()), 32'(logAdr.size()));
    for (int i = 0; i < expAdr.size(); i++) begin
      checkEq($sformatf("%s store %0d adr", name, i), 32'(expAdr[i]), 32'(logAdr[i]));
      checkEq($sformatf("%s store %0d dat", name, i), 32'(expDat[i]), 32'(logDat[i]));
    end
  endtask

  task automatic runProgram(input string name);
    applyReset();
    waitForHalt(name);
    checkStores(name);
  endtask

  task automatic aluTest();
    procPkg::wordT a;
    procPkg::wordT b;
    a = 16'h0064;
    b = 16'hfffd;   // lbi -3 after sign extension
    padCount = 3;
    newProgram();
    emit(loadImm(3'd1, 8'h64));
    emit(loadImm(3'd2, 8'hfd));
    emit(iType(procPkg::opAddi, 3'd1, 3'd3, 5'd13));
    emit(rType(procPkg::opAdd, 3'd2, 3'd2, 3'd4));   // wraps
    emit(rType(procPkg::opSub, 3'd1, 3'd2, 3'd5));
    emit(rType(procPkg::opAnd, 3'd1, 3'd2, 3'd6));
    emit(rType(procPkg::opXor, 3'd1, 3'd2, 3'd7));
    for (int r = 1; r < 8; r++) begin
      emit(iType(procPkg::opSt, 3'd0, r[2:0], r[4:0]));
    end
    emit(haltWord());
    expectStore(16'd1, a);
    expectStore(16'd2, b);
    expectStore(16'd3, a + 16'd13);
    expectStore(16'd4, b + b);
    expectStore(16'd5, a - b);
    expectStore(16'd6, a & b);
    expectStore(16'd7, a ^ b);
    runProgram("alu");
  endtask

  task automatic chainTest();
    procPkg::wordT r1, r2, r3, r4, r5, r6, r7;
    string name;
    r1 = 16'd5;
    r2 = r1 + 16'd3;
    r3 = r2 + r2;
    r4 = r3 - r1;
    r5 = r4 ^ r3;
    r6 = r5 & r4;
    r7 = r6 - 16'd1;
    for (int round = 0; round < 2; round++) begin
      if (round == 0) begin
        padCount = 3;
        name = "chain padded";
      end else begin
        padCount = 0;   // every word depends on the one before
        name = "chain back to back";
      end
      newProgram();
      emit(loadImm(3'd1, 8'd5));
      emit(iType(procPkg::opAddi, 3'd1, 3'd2, 5'd3));
      emit(rType(procPkg::opAdd, 3'd2, 3'd2, 3'd3));
      emit(rType(procPkg::opSub, 3'd3, 3'd1, 3'd4));
      emit(rType(procPkg::opXor, 3'd4, 3'd3, 3'd5));
      emit(rType(procPkg::opAnd, 3'd5, 3'd4, 3'd6));
      emit(iType(procPkg::opSt, 3'd0, 3'd6, 5'd0));
      emit(iType(procPkg::opAddi, 3'd6, 3'd7, 5'h1f));
      emit(iType(procPkg::opSt, 3'd6, 3'd7, 5'd2));   // base from r6
      emit(haltWord());
      expectStore(16'd0, r6);
      expectStore(r6 + 16'd2, r7);
      runProgram(name);
    end
  endtask

  task automatic memTest();
    procPkg::wordT sum;
    padCount = 0;
    newProgram();
    emit(loadImm(3'd1, 8'd32));
    emit(iType(procPkg::opLd, 3'd1, 3'd2, 5'd0));
    emit(iType(procPkg::opLd, 3'd1, 3'd3, 5'd1));
    emit(rType(procPkg::opAdd, 3'd2, 3'd3, 3'd4));
    emit(iType(procPkg::opSt, 3'd1, 3'd4, 5'd2));
    emit(iType(procPkg::opLd, 3'd1, 3'd5, 5'd2));    // reads back the sum
    emit(iType(procPkg::opLd, 3'd1, 3'd6, 5'h1f));   // one below the base
    emit(rType(procPkg::opXor, 3'd5, 3'd6, 3'd7));
    emit(iType(procPkg::opSt, 3'd1, 3'd7, 5'd3));
    emit(iType(procPkg::opSt, 3'd0, 3'd2, 5'd5));
    emit(haltWord());
    sum = fillWord(8'd32) + fillWord(8'd33);
    expectStore(16'd34, sum);
    expectStore(16'd35, sum ^ fillWord(8'd31));
    expectStore(16'd5, fillWord(8'd32));
    runProgram("load store");
  endtask

  task automatic flowTest();
    padCount = 0;
    newProgram();
    emit(loadImm(3'd1, 8'd0));
    emit(loadImm(3'd2, 8'd7));
    emit(loadImm(3'd6, 8'hff));                     // poison
    emit(branchZero(3'd1, 8'd1));                   // taken, to word 5
    emit(iType(procPkg::opSt, 3'd0, 3'd6, 5'd1));
    emit(iType(procPkg::opSt, 3'd0, 3'd2, 5'd2));
    emit(branchZero(3'd2, 8'd1));                   // not taken
    emit(iType(procPkg::opSt, 3'd0, 3'd2, 5'd3));
    emit(jumpRel(11'd1));                           // to word 10
    emit(iType(procPkg::opSt, 3'd0, 3'd6, 5'd4));
    emit(iType(procPkg::opSt, 3'd0, 3'd2, 5'd5));
    emit(haltWord());
    expectStore(16'd2, 16'd7);
    expectStore(16'd3, 16'd7);
    expectStore(16'd5, 16'd7);
    runProgram("control flow");
  endtask

  task automatic haltTest();
    padCount = 0;
    newProgram();
    emit(loadImm(3'd1, 8'd9));
    emit(iType(procPkg::opSt, 3'd0, 3'd1, 5'd6));
    emit(haltWord());
    emit(iType(procPkg::opSt, 3'd0, 3'd1, 5'd7));   // never issued
    expectStore(16'd6, 16'd9);
    runProgram("halt");
    repeat (20) @(posedge clk);
    #1;
    checkEq("halt stays high", 32'd1, 32'(halted));
    checkEq("halt bus idle", 32'd0, 32'(busAfterHalt));
    checkEq("halt no err", 32'd0, 32'(err));
    checkStores("halt after idle");

    newProgram();
    emit(loadImm(3'd2, 8'h3c));
    emit(iType(procPkg::opSt, 3'd0, 3'd2, 5'd8));
    emit(iType(procPkg::opAddi, 3'd2, 3'd3, 5'd1));
    emit(iType(procPkg::opSt, 3'd0, 3'd3, 5'd9));
    emit({5'b11111, 11'd0});                        // undefined opcode
    emit(iType(procPkg::opSt, 3'd0, 3'd2, 5'd10));
    expectStore(16'd8, 16'h003c);
    expectStore(16'd9, 16'h003d);
    runProgram("illegal");
    checkEq("illegal err", 32'd1, 32'(err));
  endtask

  initial begin
    rstN         = 1'b0;
    wbAck        = 1'b0;
    wbDatR       = '0;
    rngState     = 32'hb9cc;
    pending      = 1'b0;
    waitLeft     = 2'd0;
    busAfterHalt = 1'b0;
    padCount     = 0;
    newProgram();
    aluTest();
    chainTest();
    memTest();
    flowTest();
    haltTest();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* verilog.f */
hw/procPkg.sv
hw/regFile.sv
hw/decodeUnit.sv
hw/hazardDetector.sv
hw/executeUnit.sv
hw/memoryAccess.sv
hw/pipeProc.sv
testbench/procTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = procTb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
